//--- emu_ckpt_stream_out.sv
`timescale 1ns/1ps
`include "emu_macros.svh"

module emu_ckpt_stream_out import emu_scan_pkg::*; (
    input  logic       clk,
    input  logic       rst,
    input  scan_word_t in_data,
    input  logic       in_valid,
    output logic       in_ready,
    output scan_word_t ckpt_data,
    output logic       ckpt_valid,
    input  logic       ckpt_ready,
    output logic       ckpt_last,
    output logic       ckpt_done
);

    scan_cnt_t word_cnt;
    logic      in_fire;
    logic      out_fire;
    logic      at_last;

    // Output register refills in the same cycle it drains
    assign in_ready = !ckpt_valid || ckpt_ready;
    assign in_fire = in_valid && in_ready;
    assign out_fire = ckpt_valid && ckpt_ready;
    assign at_last = (word_cnt == scan_cnt_t'(`EMU_CHAIN_FF_WORDS - 1));
    assign ckpt_done = out_fire && ckpt_last;

    always_ff @(posedge clk) begin
        if (rst) begin
            ckpt_valid <= 1'b0;
            ckpt_last <= 1'b0;
            word_cnt <= '0;
        end else if (in_fire) begin
            ckpt_valid <= 1'b1;
            ckpt_last <= at_last;
            word_cnt <= at_last ? '0 : word_cnt + scan_cnt_t'(1);
        end else if (out_fire) begin
            ckpt_valid <= 1'b0;
            ckpt_last <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (in_fire) begin
            ckpt_data <= in_data;
        end
    end

endmodule

//--- emu_controller_top.sv
`timescale 1ns/1ps
`include "emu_macros.svh"

module emu_controller_top import emu_csr_pkg::*, emu_scan_pkg::*; (
    input  logic                              clk,
    input  logic                              rst,
    input  logic                              awvalid,
    output logic                              awready,
    input  csr_addr_t                         awaddr,
    input  logic                              wvalid,
    output logic                              wready,
    input  csr_data_t                         wdata,
    input  logic [`EMU_CSR_DATA_WIDTH/8-1:0]  wstrb,
    output logic                              bvalid,
    input  logic                              bready,
    output axi_resp_t                         bresp,
    input  logic                              arvalid,
    output logic                              arready,
    input  csr_addr_t                         araddr,
    output logic                              rvalid,
    input  logic                              rready,
    output csr_data_t                         rdata,
    output axi_resp_t                         rresp,
    output logic                              dut_clk_en,
    output logic                              dut_rst,
    input  logic                              dut_stall,
    input  trig_t                             dut_trig,
    output logic                              ff_se,
    output logic                              ff_clk_en,
    output scan_word_t                        ff_di,
    input  scan_word_t                        ff_do,
    output scan_word_t                        ckpt_data,
    output logic                              ckpt_valid,
    input  logic                              ckpt_ready,
    output logic                              ckpt_last
);

    logic       stat_wr;
    logic       step_wr;
    logic       cycle_lo_wr;
    logic       cycle_hi_wr;
    csr_data_t  wr_data;
    logic       pause;
    logic       step_trig_flag;
    trig_t      trig_stat;
    cycle_t     cycle;
    csr_data_t  step;
    logic       ckpt_start;
    logic       ckpt_done;
    logic       scan_active;
    scan_word_t push_data;
    logic       push_valid;
    logic       push_ready;
    scan_word_t fifo_data;
    logic       fifo_valid;
    logic       fifo_ready;

    emu_csr_slave u_csr (
        .clk            (clk),
        .rst            (rst),
        .awvalid        (awvalid),
        .awready        (awready),
        .awaddr         (awaddr),
        .wvalid         (wvalid),
        .wready         (wready),
        .wdata          (wdata),
        .wstrb          (wstrb),
        .bvalid         (bvalid),
        .bready         (bready),
        .bresp          (bresp),
        .arvalid        (arvalid),
        .arready        (arready),
        .araddr         (araddr),
        .rvalid         (rvalid),
        .rready         (rready),
        .rdata          (rdata),
        .rresp          (rresp),
        .stat_wr        (stat_wr),
        .step_wr        (step_wr),
        .cycle_lo_wr    (cycle_lo_wr),
        .cycle_hi_wr    (cycle_hi_wr),
        .wr_data        (wr_data),
        .pause          (pause),
        .dut_rst        (dut_rst),
        .step_trig_flag (step_trig_flag),
        .trig_stat      (trig_stat),
        .cycle          (cycle),
        .step           (step),
        .ckpt_start     (ckpt_start),
        .ckpt_done      (ckpt_done)
    );

    emu_run_ctrl u_run (
        .clk            (clk),
        .rst            (rst),
        .stat_wr        (stat_wr),
        .step_wr        (step_wr),
        .cycle_lo_wr    (cycle_lo_wr),
        .cycle_hi_wr    (cycle_hi_wr),
        .wr_data        (wr_data),
        .dut_stall      (dut_stall),
        .dut_trig       (dut_trig),
        .scan_active    (scan_active),
        .dut_clk_en     (dut_clk_en),
        .pause          (pause),
        .dut_rst        (dut_rst),
        .step_trig_flag (step_trig_flag),
        .trig_stat      (trig_stat),
        .cycle          (cycle),
        .step           (step)
    );

    emu_scan_producer u_scan (
        .clk         (clk),
        .rst         (rst),
        .ckpt_start  (ckpt_start),
        .ff_do       (ff_do),
        .ff_se       (ff_se),
        .ff_clk_en   (ff_clk_en),
        .ff_di       (ff_di),
        .scan_active (scan_active),
        .push_data   (push_data),
        .push_valid  (push_valid),
        .push_ready  (push_ready)
    );

    emu_word_fifo #(
        .item_t (scan_word_t),
        .DEPTH  (`EMU_FIFO_DEPTH)
    ) u_fifo (
        .clk       (clk),
        .rst       (rst),
        .in_data   (push_data),
        .in_valid  (push_valid),
        .in_ready  (push_ready),
        .out_data  (fifo_data),
        .out_valid (fifo_valid),
        .out_ready (fifo_ready)
    );

    emu_ckpt_stream_out u_out (
        .clk        (clk),
        .rst        (rst),
        .in_data    (fifo_data),
        .in_valid   (fifo_valid),
        .in_ready   (fifo_ready),
        .ckpt_data  (ckpt_data),
        .ckpt_valid (ckpt_valid),
        .ckpt_ready (ckpt_ready),
        .ckpt_last  (ckpt_last),
        .ckpt_done  (ckpt_done)
    );

endmodule

//--- emu_csr_pkg.sv
`include "emu_macros.svh"

package emu_csr_pkg;

    typedef logic [`EMU_CSR_ADDR_WIDTH-1:0] csr_addr_t;
    typedef logic [`EMU_CSR_DATA_WIDTH-1:0] csr_data_t;
    typedef logic [63:0] cycle_t;
    typedef logic [`EMU_TRIG_WIDTH-1:0] trig_t;
    typedef logic [1:0] axi_resp_t;

    localparam axi_resp_t RESP_OKAY = 2'b00;
    localparam axi_resp_t RESP_SLVERR = 2'b10;

    // Bit positions in EMU_STAT and EMU_CKPT_CTRL
    localparam int STAT_PAUSE = 0;
    localparam int STAT_DUT_RST = 1;
    localparam int STAT_STEP_TRIG = 31;
    localparam int CKPT_START = 0;
    localparam int CKPT_BUSY = 1;

endpackage

//--- emu_csr_slave.sv
`timescale 1ns/1ps
`include "emu_macros.svh"

module emu_csr_slave import emu_csr_pkg::*; (
    input  logic                              clk,
    input  logic                              rst,
    input  logic                              awvalid,
    output logic                              awready,
    input  csr_addr_t                         awaddr,
    input  logic                              wvalid,
    output logic                              wready,
    input  csr_data_t                         wdata,
    input  logic [`EMU_CSR_DATA_WIDTH/8-1:0]  wstrb,
    output logic                              bvalid,
    input  logic                              bready,
    output axi_resp_t                         bresp,
    input  logic                              arvalid,
    output logic                              arready,
    input  csr_addr_t                         araddr,
    output logic                              rvalid,
    input  logic                              rready,
    output csr_data_t                         rdata,
    output axi_resp_t                         rresp,
    output logic                              stat_wr,
    output logic                              step_wr,
    output logic                              cycle_lo_wr,
    output logic                              cycle_hi_wr,
    output csr_data_t                         wr_data,
    input  logic                              pause,
    input  logic                              dut_rst,
    input  logic                              step_trig_flag,
    input  trig_t                             trig_stat,
    input  cycle_t                            cycle,
    input  csr_data_t                         step,
    output logic                              ckpt_start,
    input  logic                              ckpt_done
);

    csr_addr_t aw_addr;
    csr_data_t w_data;
    logic      aw_held;
    logic      w_held;
    logic      w_err;
    logic      b_err;
    logic      do_write;
    csr_addr_t ar_addr;
    logic      ar_held;
    csr_data_t rd_mux;
    logic      ckpt_busy;

    assign awready = !aw_held && !bvalid;
    assign wready = !w_held;
    assign bresp = b_err ? RESP_SLVERR : RESP_OKAY;

    // Partial strobes complete the handshake but change nothing
    assign do_write = aw_held && w_held && !w_err;
    assign wr_data = w_data;

    assign stat_wr = do_write && (aw_addr == `EMU_STAT);
    assign step_wr = do_write && (aw_addr == `EMU_STEP);
    assign cycle_lo_wr = do_write && (aw_addr == `EMU_CYCLE_LO);
    assign cycle_hi_wr = do_write && (aw_addr == `EMU_CYCLE_HI);
    assign ckpt_start = do_write && (aw_addr == `EMU_CKPT_CTRL)
                        && w_data[CKPT_START] && !ckpt_busy;

    always_ff @(posedge clk) begin
        if (rst) begin
            aw_held <= 1'b0;
            w_held <= 1'b0;
            bvalid <= 1'b0;
            b_err <= 1'b0;
        end else begin
            if (bvalid && bready) begin
                bvalid <= 1'b0;
            end
            if (awvalid && awready) begin
                aw_held <= 1'b1;
            end
            if (wvalid && wready) begin
                w_held <= 1'b1;
            end
            if (aw_held && w_held) begin
                aw_held <= 1'b0;
                w_held <= 1'b0;
                bvalid <= 1'b1;
                b_err <= w_err;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (awvalid && awready) begin
            aw_addr <= awaddr;
        end
        if (wvalid && wready) begin
            w_data <= wdata;
            w_err <= (wstrb != '1);
        end
    end

    // Checkpoint in flight until the last word leaves the stream
    always_ff @(posedge clk) begin
        if (rst) begin
            ckpt_busy <= 1'b0;
        end else if (ckpt_start) begin
            ckpt_busy <= 1'b1;
        end else if (ckpt_done) begin
            ckpt_busy <= 1'b0;
        end
    end

    always_comb begin
        rd_mux = '0;
        case (ar_addr)
            `EMU_STAT: begin
                rd_mux[STAT_PAUSE] = pause;
                rd_mux[STAT_DUT_RST] = dut_rst;
                rd_mux[STAT_STEP_TRIG] = step_trig_flag;
            end
            `EMU_TRIG_STAT: rd_mux = trig_stat;
            `EMU_CYCLE_LO: rd_mux = cycle[31:0];
            `EMU_CYCLE_HI: rd_mux = cycle[63:32];
            `EMU_STEP: rd_mux = step;
            `EMU_CKPT_SIZE: rd_mux = csr_data_t'(8 * `EMU_CHAIN_FF_WORDS);
            `EMU_CKPT_CTRL: rd_mux[CKPT_BUSY] = ckpt_busy;
            default: rd_mux = '0;
        endcase
    end

    assign arready = !ar_held;
    assign rresp = RESP_OKAY;

    always_ff @(posedge clk) begin
        if (rst) begin
            ar_held <= 1'b0;
            rvalid <= 1'b0;
        end else begin
            if (arvalid && arready) begin
                ar_held <= 1'b1;
            end
            if (ar_held && !rvalid) begin
                rvalid <= 1'b1;
            end
            if (rvalid && rready) begin
                ar_held <= 1'b0;
                rvalid <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (arvalid && arready) begin
            ar_addr <= araddr;
        end
        if (ar_held && !rvalid) begin
            rdata <= rd_mux;
        end
    end

    // A write response is never withdrawn before the master takes it
    assert property (@(posedge clk) disable iff (rst) bvalid && !bready |=> bvalid);

endmodule

//--- emu_macros.svh
`ifndef EMU_MACROS_SVH
`define EMU_MACROS_SVH

// Flip-flop scan chain geometry
`define EMU_CHAIN_FF_WORDS 8
`define EMU_WORD_WIDTH 64

// AXI-lite register bus
`define EMU_CSR_ADDR_WIDTH 12
`define EMU_CSR_DATA_WIDTH 32

// External trigger vector
`define EMU_TRIG_WIDTH 32

// Checkpoint word buffer
`define EMU_FIFO_DEPTH 4

// Register map
`define EMU_STAT 12'h000
`define EMU_TRIG_STAT 12'h004
`define EMU_CYCLE_LO 12'h008
`define EMU_CYCLE_HI 12'h00C
`define EMU_STEP 12'h010
`define EMU_CKPT_SIZE 12'h014
`define EMU_CKPT_CTRL 12'h018

`endif

//--- emu_run_ctrl.sv
`timescale 1ns/1ps
`include "emu_macros.svh"

module emu_run_ctrl import emu_csr_pkg::*; (
    input  logic      clk,
    input  logic      rst,
    input  logic      stat_wr,
    input  logic      step_wr,
    input  logic      cycle_lo_wr,
    input  logic      cycle_hi_wr,
    input  csr_data_t wr_data,
    input  logic      dut_stall,
    input  trig_t     dut_trig,
    input  logic      scan_active,
    output logic      dut_clk_en,
    output logic      pause,
    output logic      dut_rst,
    output logic      step_trig_flag,
    output trig_t     trig_stat,
    output cycle_t    cycle,
    output csr_data_t step
);

    csr_data_t step_next;
    logic      step_hit;
    logic      trigger;

    assign dut_clk_en = !(pause || dut_stall || scan_active);

    // Countdown only moves on cycles the DUT actually advances
    assign step_next = (dut_clk_en && step != '0) ? step - 1'b1 : step;
    assign step_hit = (step != '0) && (step_next == '0);
    assign trigger = step_hit || (|dut_trig);

    always_ff @(posedge clk) begin
        if (rst) begin
            step <= '0;
        end else if (step_wr) begin
            step <= wr_data;
        end else begin
            step <= step_next;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            pause <= 1'b1;
            dut_rst <= 1'b1;
            step_trig_flag <= 1'b0;
            trig_stat <= '0;
        end else begin
            if (stat_wr) begin
                pause <= wr_data[STAT_PAUSE];
                dut_rst <= wr_data[STAT_DUT_RST];
            end
            // Any trigger wins over a software unpause
            if (trigger) begin
                pause <= 1'b1;
                step_trig_flag <= step_hit;
                trig_stat <= dut_trig;
            end
        end
    end

    // Software may only load the counter while the DUT clock is stopped
    always_ff @(posedge clk) begin
        if (rst) begin
            cycle <= '0;
        end else if (dut_clk_en) begin
            cycle <= cycle + 1'b1;
        end else begin
            if (cycle_lo_wr) begin
                cycle[31:0] <= wr_data;
            end
            if (cycle_hi_wr) begin
                cycle[63:32] <= wr_data;
            end
        end
    end

    assert property (@(posedge clk) disable iff (rst)
        !dut_clk_en && !cycle_lo_wr && !cycle_hi_wr |=> $stable(cycle));

endmodule

//--- emu_scan_pkg.sv
`include "emu_macros.svh"

package emu_scan_pkg;

    // One word of the flip-flop chain
    typedef logic [`EMU_WORD_WIDTH-1:0] scan_word_t;

    // Holds 0 up to a full chain of words
    typedef logic [$clog2(`EMU_CHAIN_FF_WORDS + 1)-1:0] scan_cnt_t;

endpackage

//--- emu_scan_producer.sv
`timescale 1ns/1ps
`include "emu_macros.svh"

module emu_scan_producer import emu_scan_pkg::*; (
    input  logic       clk,
    input  logic       rst,
    input  logic       ckpt_start,
    input  scan_word_t ff_do,
    output logic       ff_se,
    output logic       ff_clk_en,
    output scan_word_t ff_di,
    output logic       scan_active,
    output scan_word_t push_data,
    output logic       push_valid,
    input  logic       push_ready
);

    scan_cnt_t word_cnt;
    logic      push;
    logic      last_push;

    assign push_valid = scan_active;
    assign push_data = ff_do;
    assign push = push_valid && push_ready;
    assign last_push = push && (word_cnt == scan_cnt_t'(`EMU_CHAIN_FF_WORDS - 1));

    // Chain shifts only when its head word was accepted, so a full FIFO stalls it
    assign ff_se = scan_active;
    assign ff_clk_en = push;

    // Words rotate back in so the chain ends where it started
    assign ff_di = ff_do;

    always_ff @(posedge clk) begin
        if (rst) begin
            scan_active <= 1'b0;
            word_cnt <= '0;
        end else if (ckpt_start) begin
            scan_active <= 1'b1;
            word_cnt <= '0;
        end else if (last_push) begin
            scan_active <= 1'b0;
            word_cnt <= '0;
        end else if (push) begin
            word_cnt <= word_cnt + scan_cnt_t'(1);
        end
    end

    assert property (@(posedge clk) disable iff (rst) ff_clk_en |-> ff_se);

endmodule

//--- emu_word_fifo.sv
`timescale 1ns/1ps
`include "emu_macros.svh"

module emu_word_fifo #(
    parameter type item_t = logic [`EMU_WORD_WIDTH-1:0],
    parameter int  DEPTH = `EMU_FIFO_DEPTH
) (
    input  logic  clk,
    input  logic  rst,
    input  item_t in_data,
    input  logic  in_valid,
    output logic  in_ready,
    output item_t out_data,
    output logic  out_valid,
    input  logic  out_ready
);

    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    item_t            mem [DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] fill;
    logic             push;
    logic             pop;

    // Wrap explicitly so depths other than powers of two work
    function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
        return (ptr == PTR_W'(DEPTH - 1)) ? '0 : ptr + PTR_W'(1);
    endfunction

    assign in_ready = (fill != CNT_W'(DEPTH));
    assign out_valid = (fill != '0);
    assign out_data = mem[rd_ptr];
    assign push = in_valid && in_ready;
    assign pop = out_valid && out_ready;

    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr] <= in_data;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            fill <= '0;
        end else begin
            if (push) begin
                wr_ptr <= next_ptr(wr_ptr);
            end
            if (pop) begin
                rd_ptr <= next_ptr(rd_ptr);
            end
            if (push && !pop) begin
                fill <= fill + CNT_W'(1);
            end else if (pop && !push) begin
                fill <= fill - CNT_W'(1);
            end
        end
    end

    assert property (@(posedge clk) disable iff (rst) fill <= CNT_W'(DEPTH));

endmodule

//--- run_sim.sh
#!/usr/bin/env bash
set -eo pipefail

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    -f vlog.f --top-module tb_emu_controller -o sim_emu_controller

./obj_dir/sim_emu_controller | tee sim.log

if grep -q "Simulation failed" sim.log; then
    exit 1
fi

//--- tb_emu_controller.sv
`timescale 1ns/1ps
`include "emu_macros.svh"

module tb_emu_controller import emu_csr_pkg::*, emu_scan_pkg::*; ();

    // Bus accesses, one free run and one scan, with about four times slack
    localparam int BUS_OPS = 30;
    localparam int BUS_OP_CYCLES = 12;
    localparam int RUN_CYCLES = 200;
    localparam int CKPT_CYCLES = 16 * `EMU_CHAIN_FF_WORDS;
    localparam int TIMEOUT_CYCLES = 4 * (BUS_OPS * BUS_OP_CYCLES + RUN_CYCLES + CKPT_CYCLES);

    localparam cycle_t    CYCLE_BASE = 64'h0000_0005_FFFF_FFF0;
    localparam csr_data_t STEP_COUNT = 32'd12;
    localparam trig_t     TRIG_VALUE = 32'hA5C3_0F01;

    logic                             clk;
    logic                             rst;
    logic                             awvalid;
    logic                             awready;
    csr_addr_t                        awaddr;
    logic                             wvalid;
    logic                             wready;
    csr_data_t                        wdata;
    logic [`EMU_CSR_DATA_WIDTH/8-1:0] wstrb;
    logic                             bvalid;
    logic                             bready;
    axi_resp_t                        bresp;
    logic                             arvalid;
    logic                             arready;
    csr_addr_t                        araddr;
    logic                             rvalid;
    logic                             rready;
    csr_data_t                        rdata;
    axi_resp_t                        rresp;
    logic                             dut_clk_en;
    logic                             dut_rst;
    logic                             dut_stall;
    trig_t                            dut_trig;
    logic                             ff_se;
    logic                             ff_clk_en;
    scan_word_t                       ff_di;
    scan_word_t                       ff_do;
    scan_word_t                       ckpt_data;
    logic                             ckpt_valid;
    logic                             ckpt_ready;
    logic                             ckpt_last;

    // Flip-flop chain model, head word at index 0
    scan_word_t  chain [`EMU_CHAIN_FF_WORDS];
    scan_word_t  snap [`EMU_CHAIN_FF_WORDS];
    scan_word_t  expect_word;
    logic        expect_last;
    logic [31:0] bp_state = 32'd67;
    int          en_cycles = 0;
    int          out_idx = 0;
    int          cycle_cnt = 0;
    int          mismatch_cnt = 0;
    int          other_cnt = 0;
    string       test_name = "idle";
    logic        rd_check = 1'b0;
    csr_data_t   rd_expect = '0;
    axi_resp_t   b_expect = RESP_OKAY;

    emu_controller_top u_dut (.*);

    assign ff_do = chain[0];
    assign expect_word = snap[out_idx % `EMU_CHAIN_FF_WORDS];
    assign expect_last = (out_idx == `EMU_CHAIN_FF_WORDS - 1);

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    task automatic report_mismatch(input string name, input logic [63:0] expected,
                                   input logic [63:0] actual);
        $display("MISMATCH %s expected 0x%0h actual 0x%0h at %0t",
                 name, expected, actual, $time);
        mismatch_cnt++;
    endtask

    task automatic report_failure(input string what);
        $display("ERROR: %s at %0t", what, $time);
        other_cnt++;
    endtask

    task automatic bus_write(input string name, input csr_addr_t addr, input csr_data_t data,
                             input logic [`EMU_CSR_DATA_WIDTH/8-1:0] strb,
                             input axi_resp_t resp);
        logic aw_hs;
        logic w_hs;
        logic aw_done;
        logic w_done;
        test_name = name;
        b_expect = resp;
        aw_done = 1'b0;
        w_done = 1'b0;
        @(posedge clk);
        awvalid <= 1'b1;
        awaddr <= addr;
        wvalid <= 1'b1;
        wdata <= data;
        wstrb <= strb;
        bready <= 1'b1;
        // AW and W may complete on different edges
        while (!(aw_done && w_done)) begin
            @(negedge clk);
            aw_hs = awvalid && awready;
            w_hs = wvalid && wready;
            @(posedge clk);
            if (aw_hs) begin
                awvalid <= 1'b0;
                aw_done = 1'b1;
            end
            if (w_hs) begin
                wvalid <= 1'b0;
                w_done = 1'b1;
            end
        end
        do begin
            @(negedge clk);
        end while (!bvalid);
        @(posedge clk);
        bready <= 1'b0;
        @(negedge clk);
    endtask

    task automatic bus_read(input csr_addr_t addr);
        @(posedge clk);
        arvalid <= 1'b1;
        araddr <= addr;
        rready <= 1'b1;
        do begin
            @(negedge clk);
        end while (!arready);
        @(posedge clk);
        arvalid <= 1'b0;
        do begin
            @(negedge clk);
        end while (!rvalid);
        @(posedge clk);
        rready <= 1'b0;
        @(negedge clk);
    endtask

    task automatic check_read(input string name, input csr_addr_t addr,
                              input csr_data_t expected);
        test_name = name;
        rd_expect = expected;
        rd_check = 1'b1;
        bus_read(addr);
        rd_check = 1'b0;
    endtask

    task automatic wait_for_pause();
        do begin
            @(negedge clk);
        end while (dut_clk_en);
    endtask

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // Rotating chain, shifts only on a scan clock
    always @(posedge clk) begin
        if (ff_se && ff_clk_en) begin
            for (int i = 0; i < `EMU_CHAIN_FF_WORDS - 1; i++) begin
                chain[i] <= chain[i + 1];
            end
            chain[`EMU_CHAIN_FF_WORDS - 1] <= ff_di;
        end
    end

    // Random stream back-pressure
    always @(posedge clk) begin
        bp_state <= xorshift32(bp_state);
        ckpt_ready <= bp_state[7];
    end

    always @(negedge clk) begin
        if (!rst && dut_clk_en) begin
            en_cycles <= en_cycles + 1;
        end
    end

    always @(posedge clk) begin
        if (!rst && ckpt_valid && ckpt_ready) begin
            out_idx <= out_idx + 1;
        end
    end

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt == TIMEOUT_CYCLES) begin
            $display("ERROR: test sequence still running after %0d cycles", TIMEOUT_CYCLES);
            $display("Errors: %0d mismatches, %0d other failures", mismatch_cnt, other_cnt + 1);
            $display("Simulation failed");
            $finish;
        end
    end

    assert property (@(posedge clk) disable iff (rst)
        rvalid && rready && rd_check |-> rdata == rd_expect)
        else report_mismatch(test_name, 64'(rd_expect), 64'(rdata));

    assert property (@(posedge clk) disable iff (rst)
        rvalid && rready |-> rresp == RESP_OKAY)
        else report_mismatch({test_name, "_rresp"}, 64'(RESP_OKAY), 64'($sampled(rresp)));

    assert property (@(posedge clk) disable iff (rst)
        bvalid && bready |-> bresp == b_expect)
        else report_mismatch({test_name, "_bresp"}, 64'(b_expect), 64'(bresp));

    // Stream words leave in chain order
    assert property (@(posedge clk) disable iff (rst)
        ckpt_valid && ckpt_ready |-> ckpt_data == expect_word)
        else report_mismatch("ckpt_data", $sampled(expect_word), $sampled(ckpt_data));

    assert property (@(posedge clk) disable iff (rst)
        ckpt_valid && ckpt_ready |-> ckpt_last == expect_last)
        else report_mismatch("ckpt_last", 64'($sampled(expect_last)), 64'($sampled(ckpt_last)));

    assert property (@(posedge clk) disable iff (rst) ff_clk_en |-> ff_di == chain[0])
        else report_mismatch("ff_di", $sampled(chain[0]), $sampled(ff_di));

    assert property (@(posedge clk) disable iff (rst) ff_se |-> !dut_clk_en)
        else report_failure("DUT clock enabled during a checkpoint scan");

    initial begin
        logic [31:0] rnd;
        logic [31:0] hi_word;
        int          start;
        cycle_t      exp_cycle;
        rst <= 1'b1;
        awvalid <= 1'b0;
        awaddr <= '0;
        wvalid <= 1'b0;
        wdata <= '0;
        wstrb <= '0;
        bready <= 1'b0;
        arvalid <= 1'b0;
        araddr <= '0;
        rready <= 1'b0;
        dut_stall <= 1'b0;
        dut_trig <= '0;
        ckpt_ready <= 1'b0;
        rnd = 32'd67;
        for (int i = 0; i < `EMU_CHAIN_FF_WORDS; i++) begin
            rnd = xorshift32(rnd);
            hi_word = rnd;
            rnd = xorshift32(rnd);
            chain[i] <= {hi_word, rnd};
        end
        repeat (8) @(posedge clk);
        rst <= 1'b0;
        @(negedge clk);

        assert (!dut_clk_en) else report_mismatch("reset_clk_en", 64'd0, 64'(dut_clk_en));
        assert (dut_rst) else report_mismatch("reset_dut_rst", 64'd1, 64'(dut_rst));
        check_read("reset_stat", `EMU_STAT, (32'h1 << STAT_PAUSE) | (32'h1 << STAT_DUT_RST));
        check_read("reset_ckpt_size", `EMU_CKPT_SIZE, 32'd64);

        bus_write("partial_strobe", `EMU_STEP, 32'h0000_1234, 4'b0011, RESP_SLVERR);
        check_read("partial_strobe_step", `EMU_STEP, 32'h0);
        bus_write("full_write", `EMU_STEP, 32'hCAFE_0042, 4'hF, RESP_OKAY);
        check_read("full_write_step", `EMU_STEP, 32'hCAFE_0042);
        bus_write("step_clear", `EMU_STEP, 32'h0, 4'hF, RESP_OKAY);
        bus_write("release_reset", `EMU_STAT, 32'h1 << STAT_PAUSE, 4'hF, RESP_OKAY);
        check_read("release_reset_stat", `EMU_STAT, 32'h1 << STAT_PAUSE);
        assert (!dut_rst) else report_mismatch("release_dut_rst", 64'd0, 64'(dut_rst));

        // Low word close to wrapping so the run carries into the high word
        bus_write("cycle_lo_load", `EMU_CYCLE_LO, CYCLE_BASE[31:0], 4'hF, RESP_OKAY);
        bus_write("cycle_hi_load", `EMU_CYCLE_HI, CYCLE_BASE[63:32], 4'hF, RESP_OKAY);
        check_read("cycle_lo_load", `EMU_CYCLE_LO, CYCLE_BASE[31:0]);
        check_read("cycle_hi_load", `EMU_CYCLE_HI, CYCLE_BASE[63:32]);
        start = en_cycles;
        bus_write("cycle_run", `EMU_STAT, 32'h0, 4'hF, RESP_OKAY);
        repeat (10) @(posedge clk);
        dut_stall <= 1'b1;
        repeat (6) @(posedge clk);
        dut_stall <= 1'b0;
        repeat (20) @(posedge clk);
        bus_write("cycle_stop", `EMU_STAT, 32'h1 << STAT_PAUSE, 4'hF, RESP_OKAY);
        exp_cycle = CYCLE_BASE + cycle_t'(en_cycles - start);
        check_read("cycle_lo_run", `EMU_CYCLE_LO, exp_cycle[31:0]);
        check_read("cycle_hi_run", `EMU_CYCLE_HI, exp_cycle[63:32]);

        bus_write("step_load", `EMU_STEP, STEP_COUNT, 4'hF, RESP_OKAY);
        start = en_cycles;
        bus_write("step_run", `EMU_STAT, 32'h0, 4'hF, RESP_OKAY);
        wait_for_pause();
        assert (en_cycles - start == STEP_COUNT)
            else report_mismatch("step_cycles", 64'(STEP_COUNT), 64'(en_cycles - start));
        check_read("step_stat", `EMU_STAT, (32'h1 << STAT_STEP_TRIG) | (32'h1 << STAT_PAUSE));
        check_read("step_done", `EMU_STEP, 32'h0);

        bus_write("trig_run", `EMU_STAT, 32'h0, 4'hF, RESP_OKAY);
        @(posedge clk);
        dut_trig <= TRIG_VALUE;
        @(posedge clk);
        dut_trig <= '0;
        wait_for_pause();
        check_read("trig_capture", `EMU_TRIG_STAT, TRIG_VALUE);
        check_read("trig_stat", `EMU_STAT, 32'h1 << STAT_PAUSE);

        // Scan taken while the DUT runs, so only the scan holds its clock
        bus_write("ckpt_run", `EMU_STAT, 32'h0, 4'hF, RESP_OKAY);
        for (int i = 0; i < `EMU_CHAIN_FF_WORDS; i++) begin
            snap[i] = chain[i];
        end
        bus_write("ckpt_start", `EMU_CKPT_CTRL, 32'h1 << CKPT_START, 4'hF, RESP_OKAY);
        while (out_idx < `EMU_CHAIN_FF_WORDS) begin
            @(negedge clk);
        end
        check_read("ckpt_busy_clear", `EMU_CKPT_CTRL, 32'h0);
        for (int i = 0; i < `EMU_CHAIN_FF_WORDS; i++) begin
            assert (chain[i] == snap[i])
                else report_mismatch("chain_restore", snap[i], chain[i]);
        end

        $display("Errors: %0d mismatches, %0d other failures", mismatch_cnt, other_cnt);
        if (mismatch_cnt == 0 && other_cnt == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

//--- vlog.f
+incdir+.
emu_csr_pkg.sv
emu_scan_pkg.sv
emu_csr_slave.sv
emu_run_ctrl.sv
emu_scan_producer.sv
emu_word_fifo.sv
emu_ckpt_stream_out.sv
emu_controller_top.sv
tb_emu_controller.sv
